// File: source/opc5ls_pkg.sv
package opc5ls_pkg;

   // opcodes in instruction-set order
   localparam logic [3:0] op_mov  = 4'h0;
   localparam logic [3:0] op_and  = 4'h1;
   localparam logic [3:0] op_or   = 4'h2;
   localparam logic [3:0] op_xor  = 4'h3;
   localparam logic [3:0] op_add  = 4'h4;
   localparam logic [3:0] op_adc  = 4'h5;
   localparam logic [3:0] op_sto  = 4'h6;
   localparam logic [3:0] op_ld   = 4'h7;
   localparam logic [3:0] op_ror  = 4'h8;
   localparam logic [3:0] op_not  = 4'h9;
   localparam logic [3:0] op_sub  = 4'hA;
   localparam logic [3:0] op_sbc  = 4'hB;
   localparam logic [3:0] op_cmp  = 4'hC;
   localparam logic [3:0] op_cmpc = 4'hD;
   localparam logic [3:0] op_bswp = 4'hE;
   localparam logic [3:0] op_psr  = 4'hF;

   localparam logic [2:0] st_fetch0 = 3'h0;   // first instruction word
   localparam logic [2:0] st_fetch1 = 3'h1;   // immediate word
   localparam logic [2:0] st_ea_ed  = 3'h2;   // effective address / predicate re-check
   localparam logic [2:0] st_rdmem  = 3'h3;
   localparam logic [2:0] st_exec   = 3'h4;
   localparam logic [2:0] st_wrmem  = 3'h5;

   localparam logic [3:0] reg_zero = 4'h0;    // r0 reads as zero
   localparam logic [3:0] reg_pc   = 4'hF;    // r15 reads as pc

   typedef struct packed {
      logic       pred_c;                     // bit 15
      logic       pred_z;                     // bit 14
      logic       invert;                     // bit 13
      logic       len;                        // two-word instruction
      logic [3:0] opcode;
      logic [3:0] src;
      logic [3:0] dst;
   } instr_t;

   // latched word plus predecode bits, 21 bits
   typedef struct packed {
      logic   is_cmp;
      logic   put_psr;
      logic   get_psr;
      logic   is_sto;
      logic   is_ld;
      instr_t word;
   } ir_t;

   typedef struct packed {
      logic carry;
      logic zero;
   } flags_t;

endpackage

// File: source/opc5ls_decode.sv
module opc5ls_decode (
   input  logic               clk,
   input  logic               reset_b,
   input  opc5ls_pkg::instr_t din,
   input  logic               load_ir,
   input  opc5ls_pkg::flags_t flags,
   input  opc5ls_pkg::flags_t next_flags,
   output opc5ls_pkg::ir_t    ir,
   output logic               pred,
   output logic               pred_din,
   output logic               pred_next
);

   opc5ls_pkg::ir_t ir_d;

   function automatic logic pred_eval(input opc5ls_pkg::instr_t w,
                                      input opc5ls_pkg::flags_t f);
      return w.invert ^ ((w.pred_c | f.carry) & (w.pred_z | f.zero));
   endfunction

   always_comb
   begin
      ir_d.is_cmp  = (din.opcode == opc5ls_pkg::op_cmp) || (din.opcode == opc5ls_pkg::op_cmpc);
      ir_d.put_psr = (din.opcode == opc5ls_pkg::op_psr) && (din.src != opc5ls_pkg::reg_zero)
                     && (din.dst == opc5ls_pkg::reg_zero);
      ir_d.get_psr = (din.opcode == opc5ls_pkg::op_psr) && (din.dst != opc5ls_pkg::reg_zero)
                     && (din.src == opc5ls_pkg::reg_zero);
      ir_d.is_sto  = din.opcode == opc5ls_pkg::op_sto;
      ir_d.is_ld   = din.opcode == opc5ls_pkg::op_ld;
      ir_d.word    = din;
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         ir <= '0;
      end
      else if (load_ir)
      begin
         ir <= ir_d;                          // fetch0 and exec only
      end
   end

   assign pred      = pred_eval(ir.word, flags);   // once ir is loaded
   assign pred_din  = pred_eval(din, flags);       // raw word in fetch0
   // exec shortcut sees the flags this instruction is about to write
   assign pred_next = pred_eval(din, next_flags);

endmodule

// File: source/opc5ls_regfile.sv
module opc5ls_regfile (
   input  logic            clk,
   input  opc5ls_pkg::ir_t ir,
   input  logic [15:0]     pc,
   input  logic            exec_en,
   input  logic [15:0]     result,
   output logic [15:0]     dst_data,
   output logic [15:0]     src_data
);

   logic [15:0] regs [16];
   logic [3:0]  wr_idx;

   assign wr_idx = ir.is_cmp ? opc5ls_pkg::reg_zero : ir.word.dst;   // compares dump into r0

   always_ff @(posedge clk)
   begin
      if (exec_en && (wr_idx != opc5ls_pkg::reg_pc))   // pc lives in the sequencer
      begin
         regs[wr_idx] <= result;
      end
   end

   // port 1 reads the destination, port 2 the source
   assign dst_data = (ir.word.dst == opc5ls_pkg::reg_pc)   ? pc :
                     (ir.word.dst == opc5ls_pkg::reg_zero) ? 16'h0000 :
                     regs[ir.word.dst];

   assign src_data = (ir.word.src == opc5ls_pkg::reg_pc)   ? pc :
                     (ir.word.src == opc5ls_pkg::reg_zero) ? 16'h0000 :
                     regs[ir.word.src];

endmodule

// File: source/opc5ls_alu.sv
module opc5ls_alu (
   input  opc5ls_pkg::ir_t    ir,
   input  logic [15:0]        dst_data,
   input  logic [15:0]        operand,
   input  opc5ls_pkg::flags_t flags,
   output logic [15:0]        result,
   output opc5ls_pkg::flags_t next_flags
);

   logic carry;

   always_comb
   begin
      result = operand;
      carry  = flags.carry;
      case (ir.word.opcode)
         opc5ls_pkg::op_mov, opc5ls_pkg::op_ld, opc5ls_pkg::op_sto, opc5ls_pkg::op_psr:
         begin
            result = ir.get_psr ? {14'b0, flags} : operand;
         end
         opc5ls_pkg::op_and, opc5ls_pkg::op_or:
         begin
            result = ir.word.opcode[0] ? (dst_data & operand) : (dst_data | operand);
         end
         opc5ls_pkg::op_add, opc5ls_pkg::op_adc:
         begin
            {carry, result} = {1'b0, dst_data} + {1'b0, operand}
                              + {16'b0, ir.word.opcode[0] & flags.carry};
         end
         opc5ls_pkg::op_sub, opc5ls_pkg::op_sbc, opc5ls_pkg::op_cmp, opc5ls_pkg::op_cmpc:
         begin
            // add the inverted operand, carry in is 1 or C
            {carry, result} = {1'b0, dst_data} + {1'b0, ~operand}
                              + {16'b0, ir.word.opcode[0] ? flags.carry : 1'b1};
         end
         opc5ls_pkg::op_xor, opc5ls_pkg::op_bswp:
         begin
            result = ir.word.opcode[3] ? {operand[7:0], operand[15:8]} : (dst_data ^ operand);
         end
         opc5ls_pkg::op_ror, opc5ls_pkg::op_not:
         begin
            if (ir.word.opcode[0])
            begin
               result = ~operand;
            end
            else
            begin
               {result, carry} = {flags.carry, operand};   // rotate through carry
            end
         end
         default:
         begin
            result = operand;
         end
      endcase

      if (ir.put_psr)
      begin
         next_flags = opc5ls_pkg::flags_t'(operand[1:0]);
      end
      else if (ir.word.dst != opc5ls_pkg::reg_pc)
      begin
         next_flags.carry = carry;
         next_flags.zero  = ~|result;
      end
      else
      begin
         next_flags = flags;                  // jumps leave C and Z alone
      end
   end

endmodule

// File: source/opc5ls_sequencer.sv
module opc5ls_sequencer (
   input  logic               clk,
   input  logic               reset_b,
   input  opc5ls_pkg::instr_t din,
   input  opc5ls_pkg::ir_t    ir,
   input  logic               pred,
   input  logic               pred_din,
   input  logic               pred_next,
   input  logic [15:0]        src_data,
   input  logic [15:0]        result,
   output logic [2:0]         state,
   output logic [15:0]        pc,
   output logic [15:0]        operand,
   output logic [15:0]        address,
   output logic               rnw,
   output logic               load_ir,
   output logic               exec_en
);

   logic [2:0]  state_nxt;
   logic [15:0] operand_q;
   logic        din_mem;                     // word on din is ld or sto
   logic        pc_write;

   assign din_mem  = (din.opcode == opc5ls_pkg::op_ld) || (din.opcode == opc5ls_pkg::op_sto);
   assign pc_write = ir.word.dst == opc5ls_pkg::reg_pc;

   always_comb
   begin
      case (state)
         opc5ls_pkg::st_fetch0:
            state_nxt = din.len  ? opc5ls_pkg::st_fetch1 :
                        !pred_din ? opc5ls_pkg::st_fetch0 :
                        din_mem  ? opc5ls_pkg::st_ea_ed : opc5ls_pkg::st_exec;
         opc5ls_pkg::st_fetch1:   // index register needs the address add
            state_nxt = !pred ? opc5ls_pkg::st_fetch0 :
                        ((ir.word.src != opc5ls_pkg::reg_zero) || ir.is_ld || ir.is_sto) ?
                        opc5ls_pkg::st_ea_ed : opc5ls_pkg::st_exec;
         opc5ls_pkg::st_ea_ed:
            state_nxt = !pred    ? opc5ls_pkg::st_fetch0 :
                        ir.is_ld  ? opc5ls_pkg::st_rdmem :
                        ir.is_sto ? opc5ls_pkg::st_wrmem : opc5ls_pkg::st_exec;
         opc5ls_pkg::st_rdmem:
            state_nxt = opc5ls_pkg::st_exec;
         opc5ls_pkg::st_exec:     // false shortcut falls back to ea_ed for the re-check
            state_nxt = pc_write  ? opc5ls_pkg::st_fetch0 :
                        din.len   ? opc5ls_pkg::st_fetch1 :
                        din_mem   ? opc5ls_pkg::st_ea_ed :
                        pred_next ? opc5ls_pkg::st_exec : opc5ls_pkg::st_ea_ed;
         default:
            state_nxt = opc5ls_pkg::st_fetch0;   // wrmem and unused codes
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         state <= opc5ls_pkg::st_fetch0;
         pc    <= 16'h0000;
      end
      else
      begin
         state <= state_nxt;
         if ((state == opc5ls_pkg::st_fetch0) || (state == opc5ls_pkg::st_fetch1))
         begin
            pc <= pc + 16'd1;
         end
         else if (state == opc5ls_pkg::st_exec)
         begin
            pc <= pc_write ? result : pc + 16'd1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      case (state)
         opc5ls_pkg::st_fetch0, opc5ls_pkg::st_exec: operand_q <= 16'h0000;
         opc5ls_pkg::st_fetch1, opc5ls_pkg::st_rdmem: operand_q <= din;   // immediate or load data
         opc5ls_pkg::st_ea_ed: operand_q <= src_data + operand_q;         // base plus offset
         default: operand_q <= operand_q;
      endcase
   end

   assign operand = (ir.word.len || ir.is_ld) ? operand_q : src_data;
   assign address = ((state == opc5ls_pkg::st_rdmem) || (state == opc5ls_pkg::st_wrmem)) ?
                    operand_q : pc;
   assign rnw     = state != opc5ls_pkg::st_wrmem;
   assign load_ir = (state == opc5ls_pkg::st_fetch0) || (state == opc5ls_pkg::st_exec);
   assign exec_en = state == opc5ls_pkg::st_exec;

endmodule

// File: source/opc5ls_cpu.sv
module opc5ls_cpu (
   input  logic [15:0] din,
   output logic [15:0] dout,
   output logic [15:0] address,
   output logic        rnw,
   input  logic        clk,
   input  logic        reset_b
);

   opc5ls_pkg::ir_t    ir;
   opc5ls_pkg::flags_t flags_q;
   opc5ls_pkg::flags_t next_flags;
   logic               pred;
   logic               pred_din;
   logic               pred_next;
   logic               load_ir;
   logic               exec_en;
   logic [15:0]        pc;
   logic [15:0]        operand;
   logic [15:0]        dst_data;
   logic [15:0]        src_data;
   logic [15:0]        result;

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         flags_q <= '0;
      end
      else if (exec_en)
      begin
         flags_q <= next_flags;               // C and Z
      end
   end

   assign dout = dst_data;                    // stores always write the destination reg

   opc5ls_decode u_decode (
      .clk        (clk),
      .reset_b    (reset_b),
      .din        (din),
      .load_ir    (load_ir),
      .flags      (flags_q),
      .next_flags (next_flags),
      .ir         (ir),
      .pred       (pred),
      .pred_din   (pred_din),
      .pred_next  (pred_next)
   );

   opc5ls_regfile u_regfile (
      .clk      (clk),
      .ir       (ir),
      .pc       (pc),
      .exec_en  (exec_en),
      .result   (result),
      .dst_data (dst_data),
      .src_data (src_data)
   );

   opc5ls_alu u_alu (
      .ir         (ir),
      .dst_data   (dst_data),
      .operand    (operand),
      .flags      (flags_q),
      .result     (result),
      .next_flags (next_flags)
   );

   opc5ls_sequencer u_sequencer (
      .clk       (clk),
      .reset_b   (reset_b),
      .din       (din),
      .ir        (ir),
      .pred      (pred),
      .pred_din  (pred_din),
      .pred_next (pred_next),
      .src_data  (src_data),
      .result    (result),
      .state     (),
      .pc        (pc),
      .operand   (operand),
      .address   (address),
      .rnw       (rnw),
      .load_ir   (load_ir),
      .exec_en   (exec_en)
   );

endmodule

// File: verif/opc5ls_mem.sv
module opc5ls_mem (
   input  logic        clk,
   input  logic [15:0] address,
   input  logic        rnw,
   input  logic [15:0] wr_data,
   output logic [15:0] rd_data
);

   logic [15:0] mem [65536];

   assign rd_data = mem[address];             // combinational read

   always @(posedge clk)
   begin
      if (!rnw)
      begin
         mem[address] <= wr_data;
      end
   end

   // every word holds its own address until a program overwrites it
   task automatic fill();
      for (int a = 0; a < 65536; a++)
      begin
         mem[a] = a[15:0];
      end
   endtask

   task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
      mem[addr] = data;
   endtask

endmodule

// File: verif/opc5ls_tb.sv
module opc5ls_tb;

   localparam int num_tests    = 7;
   localparam int num_words    = 87;
   localparam int cycle_limit  = 200;         // per test, in clocks
   localparam int reset_cycles = 5;
   localparam int clk_period   = 20;
   localparam int watchdog_time = num_tests * (cycle_limit + reset_cycles + 2) * clk_period;

   typedef struct packed {
      logic [7:0]  first;                     // index of first word in prog_words
      logic [7:0]  count;
      logic [15:0] expected;                  // value stored to 0xFFF0
   } test_row_t;

   logic        clk;
   logic        reset_b;
   logic [15:0] din;
   logic [15:0] dout;
   logic [15:0] address;
   logic        rnw;
   int          pass_count;
   int          fail_count;

   // programs load at address 0, each ends in a jump to itself
   logic [15:0] prog_words [num_words] = '{
      // mov r1,#1234  add r1,r1  sto r1,0xFFF0
      16'hD001, 16'h1234, 16'hC411, 16'hD601, 16'hFFF0, 16'hD00F, 16'h0005,
      // and, or #, xor, not, bswp chain
      16'hD001, 16'h0F0F, 16'hD002, 16'h00FF, 16'hC121, 16'hD201, 16'h3000,
      16'hC321, 16'hC913, 16'hCE34, 16'hD604, 16'hFFF0, 16'hD00F, 16'h000C,
      // 5 - 7 borrows, then sbc 0x10 - 7 - 1
      16'hD001, 16'h0005, 16'hD002, 16'h0007, 16'hD003, 16'h0010, 16'hCA21,
      16'hCB23, 16'hD603, 16'hFFF0, 16'hD00F, 16'h000A,
      // cmp equal, then nz / z / nc / c moves and a one-word z move
      16'hD001, 16'h1234, 16'hD002, 16'h1234, 16'hCC21, 16'hB001, 16'hBAD0,
      16'h9003, 16'h0040, 16'h7003, 16'hBAD1, 16'h5004, 16'h0002, 16'h8001,
      16'hC431, 16'hC441, 16'hD601, 16'hFFF0, 16'hD00F, 16'h0012,
      // ld r5 from r2 + 4, data word at address 8
      16'hD002, 16'h0004, 16'hD725, 16'h0004, 16'hD605, 16'hFFF0, 16'hD00F,
      16'h0006, 16'h5A3C,
      // jump over a bad store, then never-predicated moves
      16'hD001, 16'h00A5, 16'hD00F, 16'h0006, 16'hD600, 16'hFFF0, 16'hE001,
      16'hF001, 16'hDEAD, 16'hD601, 16'hFFF0, 16'hD00F, 16'h000B,
      // psr put C=1, ror, psr get, add
      16'hD003, 16'h0005, 16'hD001, 16'h0002, 16'hCF10, 16'hC832, 16'hCF04,
      16'hC442, 16'hD602, 16'hFFF0, 16'hD00F, 16'h000A
   };

   test_row_t tests [num_tests] = '{
      '{8'd0,  8'd7,  16'h2468},              // 0x1234 doubled
      '{8'd7,  8'd14, 16'h0FCF},              // bswp(~((0x000F | 0x3000) ^ 0x00FF))
      '{8'd21, 8'd12, 16'h0008},              // sbc sees C=0 from the borrow
      '{8'd33, 8'd20, 16'h1276},              // r1 kept by cmp, +0x40 +0x2
      '{8'd53, 8'd9,  16'h5A3C},
      '{8'd62, 8'd13, 16'h00A5},
      '{8'd75, 8'd12, 16'h8004}               // ror gives 0x8002, psr get gives 2
   };

   opc5ls_cpu DUT (
      .din     (din),
      .dout    (dout),
      .address (address),
      .rnw     (rnw),
      .clk     (clk),
      .reset_b (reset_b)
   );

   opc5ls_mem u_mem (
      .clk     (clk),
      .address (address),
      .rnw     (rnw),
      .wr_data (dout),
      .rd_data (din)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic run_test(input int t);
      test_row_t   row;
      logic        seen;
      logic [15:0] got;
      int          cycles;
      row = tests[t];
      @(negedge clk);
      reset_b = 1'b0;                         // hold the core while memory is loaded
      u_mem.fill();
      for (int i = 0; i < row.count; i++)
      begin
         u_mem.write_word(i[15:0], prog_words[row.first + i]);
      end
      repeat (reset_cycles) @(negedge clk);
      reset_b = 1'b1;
      seen   = 1'b0;
      got    = 16'h0000;
      cycles = 0;
      while (!seen && (cycles < cycle_limit))
      begin
         @(negedge clk);
         cycles++;
         if (!rnw && (address == 16'hFFF0))
         begin
            seen = 1'b1;
            got  = dout;
         end
      end
      if (!seen)
      begin
         $display("[FAIL] test %0d: no store seen within %0d cycles", t, cycle_limit);
         fail_count++;
      end
      else if (got !== row.expected)
      begin
         $display("[FAIL] test %0d: dout = 0x%04h, expected 0x%04h", t, got, row.expected);
         fail_count++;
      end
      else
      begin
         $display("[PASS] test %0d: dout = 0x%04h", t, got);
         pass_count++;
      end
   endtask

   initial
   begin
      reset_b    = 1'b0;
      pass_count = 0;
      fail_count = 0;
      u_mem.fill();                           // din is defined from the start
      for (int t = 0; t < num_tests; t++)
      begin
         run_test(t);
      end
      $display("tests run: %0d, passed: %0d, failed: %0d", num_tests, pass_count, fail_count);
      if (fail_count == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial
   begin
      #(watchdog_time);
      $display("watchdog expired before all tests finished");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: project.f
source/opc5ls_pkg.sv
source/opc5ls_decode.sv
source/opc5ls_regfile.sv
source/opc5ls_alu.sv
source/opc5ls_sequencer.sv
source/opc5ls_cpu.sv
verif/opc5ls_mem.sv
verif/opc5ls_tb.sv

// File: Bender.yml
package:
  name: opc5ls

sources:
  - source/opc5ls_pkg.sv
  - source/opc5ls_decode.sv
  - source/opc5ls_regfile.sv
  - source/opc5ls_alu.sv
  - source/opc5ls_sequencer.sv
  - source/opc5ls_cpu.sv
  - target: test
    files:
      - verif/opc5ls_mem.sv
      - verif/opc5ls_tb.sv
